//--- hdl/colmix_pkg.sv
package colmix_pkg;

    // Field widths
    localparam int IDX_W  = 7;
    localparam int BYTE_W = 8;
    localparam int ADDR_W = IDX_W + 1;
    localparam int CHAN_W = 5;
    localparam int COL_W  = 3 * CHAN_W;

    // Palette size in bytes, two bytes per colour
    localparam int PAL_DEPTH = 2 ** ADDR_W;

    // Pixel strobes from index sample to visible colour
    localparam int PIPE_DLY = 3;

    // Strobes spent fetching both bytes before the mixer latches the word
    localparam int FETCH_DLY = 2;

    // Strobe stages left for the mixer to cover
    localparam int MIX_DLY = PIPE_DLY - FETCH_DLY;

    // Index followed by the byte select bit
    typedef logic [ADDR_W-1:0] pal_addr_t;

    typedef logic [BYTE_W-1:0] pal_byte_t;

    typedef logic [IDX_W-1:0] col_index_t;

    // Blue in the top bits, red in the bottom ones
    typedef logic [COL_W-1:0] colour_t;

    typedef logic [CHAN_W-1:0] channel_t;

endpackage

//--- hdl/pal_cpu_if.sv
`timescale 1ns/1ps

// CPU side of the palette memory
interface pal_cpu_if;

    // Chip select, read not write, CPU clock enable
    logic                 cs;
    logic                 rnw;
    logic                 cen;
    colmix_pkg::pal_addr_t addr;
    colmix_pkg::pal_byte_t wdata;
    // Registered read data, one clock behind addr
    colmix_pkg::pal_byte_t rdata;

    // Memory end
    modport ram (
        input  cs, rnw, cen, addr, wdata,
        output rdata
    );

    // CPU end
    modport host (
        output cs, rnw, cen, addr, wdata,
        input  rdata
    );

endinterface

//--- hdl/video_in_if.sv
`timescale 1ns/1ps

// Pixel stream from the graphics layers
interface video_in_if;

    // High one clock in two
    logic                   pxl_cen;
    // Blanking levels, low means blanked
    logic                   lhbl;
    logic                   lvbl;
    // Colour index of the current pixel
    colmix_pkg::col_index_t pxl;

    // Video timing and layer mux side
    modport source (
        output pxl_cen, lhbl, lvbl, pxl
    );

    // Fetch and blanking paths
    modport sink (
        input pxl_cen, lhbl, lvbl, pxl
    );

endinterface

//--- hdl/palette_ram.sv
`timescale 1ns/1ps

// 256 byte palette, CPU port plus pixel read port on one clock
module palette_ram (
    input  logic                  clk,
    pal_cpu_if.ram                cpu,
    input  colmix_pkg::pal_addr_t pxl_addr,
    output colmix_pkg::pal_byte_t pxl_data
);

    // Palette storage, contents survive reset
    colmix_pkg::pal_byte_t mem [colmix_pkg::PAL_DEPTH];

    logic cpu_we;

    // Write strobe from the CPU bus
    assign cpu_we = cpu.cs & cpu.cen & ~cpu.rnw;

    // CPU port
    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu.addr] <= cpu.wdata;
        end
        // Read back always runs, old data on a write cycle
        cpu.rdata <= mem[cpu.addr];
    end

    // Pixel port, read only
    always_ff @(posedge clk) begin
        pxl_data <= mem[pxl_addr];
    end

endmodule

//--- hdl/colour_fetch.sv
`timescale 1ns/1ps

// Two byte palette fetch per pixel
module colour_fetch (
    input  logic                  clk,
    input  logic                  rst,
    video_in_if.sink              vid,
    output colmix_pkg::pal_addr_t pxl_addr,
    input  colmix_pkg::pal_byte_t pxl_data,
    output colmix_pkg::colour_t   colour,
    output logic                  colour_stb
);

    // Index of the pixel being fetched
    colmix_pkg::col_index_t idx;
    // Byte select, 0 for high byte, idles on the low byte
    logic                   phase;
    // pxl_data carries the high byte this cycle
    logic                   hi_rd;
    // pxl_data carries the low byte this cycle
    logic                   lo_rd;
    // High byte held until the low byte returns
    colmix_pkg::pal_byte_t  hi_byte;

    // High byte address right after the strobe, low byte next
    assign pxl_addr = {idx, phase};

    // Index capture
    always_ff @(posedge clk) begin
        if (vid.pxl_cen) begin
            idx <= vid.pxl;
        end
    end

    // Read sequencing
    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= 1'b1;
            hi_rd <= 1'b0;
            lo_rd <= 1'b0;
        end else begin
            // Back to the high byte on each new pixel
            phase <= ~vid.pxl_cen;
            // RAM answers one clock after the address
            hi_rd <= ~phase;
            lo_rd <= hi_rd;
        end
    end

    // Byte assembly
    always_ff @(posedge clk) begin
        if (hi_rd) begin
            hi_byte <= pxl_data;
        end
        if (lo_rd) begin
            // Bit 7 of the high byte is unused
            colour <= {hi_byte[colmix_pkg::BYTE_W-2:0], pxl_data};
        end
    end

    // One clock pulse with each new word
    always_ff @(posedge clk) begin
        if (rst) begin
            colour_stb <= 1'b0;
        end else begin
            colour_stb <= lo_rd;
        end
    end

endmodule

//--- hdl/blank_delay.sv
`timescale 1ns/1ps

// Blanking delay matched to the colour pipeline
module blank_delay (
    input  logic     clk,
    input  logic     rst,
    video_in_if.sink vid,
    output logic     lhbl_d,
    output logic     lvbl_d
);

    // In-flight blanking levels, bit 0 is the newest pixel
    logic [colmix_pkg::PIPE_DLY-1:0] hbl_sr;
    logic [colmix_pkg::PIPE_DLY-1:0] vbl_sr;

    // Horizontal blanking
    always_ff @(posedge clk) begin
        if (rst) begin
            // Start out blanked
            hbl_sr <= '0;
            lhbl_d <= 1'b0;
        end else if (vid.pxl_cen) begin
            // Pixel strobes only, so any strobe rate keeps alignment
            {lhbl_d, hbl_sr} <= {hbl_sr, vid.lhbl};
        end
    end

    // Vertical blanking, same shape
    always_ff @(posedge clk) begin
        if (rst) begin
            vbl_sr <= '0;
            lvbl_d <= 1'b0;
        end else if (vid.pxl_cen) begin
            {lvbl_d, vbl_sr} <= {vbl_sr, vid.lvbl};
        end
    end

endmodule

//--- hdl/rgb_mixer.sv
`timescale 1ns/1ps

// Final colour stage with blanking
module rgb_mixer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pxl_cen,
    input  colmix_pkg::colour_t  colour,
    input  logic                 colour_stb,
    input  logic                 lhbl_d,
    input  logic                 lvbl_d,
    output colmix_pkg::channel_t red,
    output colmix_pkg::channel_t green,
    output colmix_pkg::channel_t blue
);

    // Word from the fetch, held across the next strobe
    colmix_pkg::colour_t col_lat;
    // Strobe stages still to go before display
    colmix_pkg::colour_t col_sr [colmix_pkg::MIX_DLY];
    // Colour on screen, gated by blanking
    colmix_pkg::colour_t col_vis;
    logic                blanked;

    // Catch each word as it arrives
    always_ff @(posedge clk) begin
        if (colour_stb) begin
            col_lat <= colour;
        end
    end

    // Advance with the pixel strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < colmix_pkg::MIX_DLY; i++) begin
                col_sr[i] <= '0;
            end
        end else if (pxl_cen) begin
            col_sr[0] <= col_lat;
            for (int i = 1; i < colmix_pkg::MIX_DLY; i++) begin
                col_sr[i] <= col_sr[i-1];
            end
        end
    end

    // Delayed flags change on the same strobe as the last stage
    assign blanked = ~lhbl_d | ~lvbl_d;
    assign col_vis = blanked ? '0 : col_sr[colmix_pkg::MIX_DLY-1];

    // Red low, green middle, blue high
    assign red   = col_vis[colmix_pkg::CHAN_W-1:0];
    assign green = col_vis[2*colmix_pkg::CHAN_W-1:colmix_pkg::CHAN_W];
    assign blue  = col_vis[3*colmix_pkg::CHAN_W-1:2*colmix_pkg::CHAN_W];

endmodule

//--- hdl/colmix_top.sv
`timescale 1ns/1ps

// Palette colour mixer top level
module colmix_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pxl_cen,
    input  logic                   lhbl,
    input  logic                   lvbl,
    input  colmix_pkg::col_index_t gfx_pxl,
    input  logic                   pal_cs,
    input  logic                   cpu_rnw,
    input  logic                   cpu_cen,
    input  colmix_pkg::pal_addr_t  cpu_addr,
    input  colmix_pkg::pal_byte_t  cpu_dout,
    output colmix_pkg::pal_byte_t  pal_dout,
    output logic                   lhbl_dly,
    output logic                   lvbl_dly,
    output colmix_pkg::channel_t   red,
    output colmix_pkg::channel_t   green,
    output colmix_pkg::channel_t   blue
);

    pal_cpu_if  cpu_bus ();
    video_in_if vid_bus ();

    // Pixel read port
    colmix_pkg::pal_addr_t pxl_addr;
    colmix_pkg::pal_byte_t pxl_data;
    // Assembled colour towards the mixer
    colmix_pkg::colour_t   colour;
    logic                  colour_stb;
    // Delayed blanking
    logic                  lhbl_d;
    logic                  lvbl_d;

    // CPU bus mapping
    assign cpu_bus.cs    = pal_cs;
    assign cpu_bus.rnw   = cpu_rnw;
    assign cpu_bus.cen   = cpu_cen;
    assign cpu_bus.addr  = cpu_addr;
    assign cpu_bus.wdata = cpu_dout;
    assign pal_dout      = cpu_bus.rdata;

    // Video input mapping
    assign vid_bus.pxl_cen = pxl_cen;
    assign vid_bus.lhbl    = lhbl;
    assign vid_bus.lvbl    = lvbl;
    assign vid_bus.pxl     = gfx_pxl;

    palette_ram u_ram (
        .clk      (clk),
        .cpu      (cpu_bus.ram),
        .pxl_addr (pxl_addr),
        .pxl_data (pxl_data)
    );

    colour_fetch u_fetch (
        .clk        (clk),
        .rst        (rst),
        .vid        (vid_bus.sink),
        .pxl_addr   (pxl_addr),
        .pxl_data   (pxl_data),
        .colour     (colour),
        .colour_stb (colour_stb)
    );

    blank_delay u_blank (
        .clk    (clk),
        .rst    (rst),
        .vid    (vid_bus.sink),
        .lhbl_d (lhbl_d),
        .lvbl_d (lvbl_d)
    );

    rgb_mixer u_mixer (
        .clk        (clk),
        .rst        (rst),
        .pxl_cen    (pxl_cen),
        .colour     (colour),
        .colour_stb (colour_stb),
        .lhbl_d     (lhbl_d),
        .lvbl_d     (lvbl_d),
        .red        (red),
        .green      (green),
        .blue       (blue)
    );

    // Blanking also goes out for the video encoder
    assign lhbl_dly = lhbl_d;
    assign lvbl_dly = lvbl_d;

endmodule

//--- tests/tb_colmix_tasks.svh
`ifndef TB_COLMIX_TASKS_SVH
`define TB_COLMIX_TASKS_SVH

// Mirror of every palette write
colmix_pkg::pal_byte_t model [colmix_pkg::PAL_DEPTH];

// Colour word for an index, high byte low 7 bits then low byte
function automatic colmix_pkg::colour_t expected_colour(input colmix_pkg::col_index_t idx);
    colmix_pkg::pal_byte_t hi;
    hi = model[{idx, 1'b0}];
    return {hi[6:0], model[{idx, 1'b1}]};
endfunction

task automatic fail_stop(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "stopped at the first failure");
endtask

task automatic check_byte(input string name, input colmix_pkg::pal_byte_t exp,
                          input colmix_pkg::pal_byte_t act);
    if (act !== exp) begin
        fail_stop($sformatf("Error in %s: expected %0h, actual %0h", name, exp, act));
    end
endtask

task automatic check_channel(input string name, input colmix_pkg::channel_t exp,
                             input colmix_pkg::channel_t act);
    if (act !== exp) begin
        fail_stop($sformatf("Error in %s: expected %0h, actual %0h", name, exp, act));
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        fail_stop($sformatf("Error in %s: expected %0b, actual %0b", name, exp, act));
    end
endtask

// Queue one pixel for the video driver
task automatic push_pixel(input colmix_pkg::col_index_t idx, input logic h, input logic v);
    stim_idx_q.push_back(idx);
    stim_hbl_q.push_back(h);
    stim_vbl_q.push_back(v);
    pushed_cnt++;
endtask

// Until every queued test pixel has been checked
task automatic wait_stream_done(input int limit);
    int n;
    n = 0;
    while (checked_cnt != pushed_cnt && n < limit) begin
        @(negedge clk);
        n++;
    end
    if (checked_cnt != pushed_cnt) begin
        fail_stop($sformatf("Timeout in %s, streamed pixels never reached the output",
                            test_name));
    end
endtask

task automatic cpu_write(input colmix_pkg::pal_addr_t addr, input colmix_pkg::pal_byte_t data);
    @(negedge clk);
    pal_cs   = 1'b1;
    cpu_cen  = 1'b1;
    cpu_rnw  = 1'b0;
    cpu_addr = addr;
    cpu_dout = data;
    model[addr] = data;
    @(negedge clk);
    pal_cs  = 1'b0;
    cpu_cen = 1'b0;
    cpu_rnw = 1'b1;
endtask

// Read data is due one clock after the address
task automatic cpu_read_check(input colmix_pkg::pal_addr_t addr);
    @(negedge clk);
    pal_cs   = 1'b1;
    cpu_cen  = 1'b1;
    cpu_rnw  = 1'b1;
    cpu_addr = addr;
    @(negedge clk);
    check_byte($sformatf("%s addr %0h", test_name, addr), model[addr], pal_dout);
    pal_cs  = 1'b0;
    cpu_cen = 1'b0;
endtask

// Oldest in-flight pixel against the outputs
task automatic check_pixel();
    logic                h;
    logic                v;
    logic                t;
    int                  num;
    colmix_pkg::colour_t c;
    h   = hbl_q.pop_front();
    v   = vbl_q.pop_front();
    t   = tag_q.pop_front();
    num = num_q.pop_front();
    c   = exp_q.pop_front();
    // Either blank level low forces black
    if (!(h && v)) begin
        c = '0;
    end
    check_flag($sformatf("%s pixel %0d lhbl_dly", test_name, num), h, lhbl_dly);
    check_flag($sformatf("%s pixel %0d lvbl_dly", test_name, num), v, lvbl_dly);
    check_channel($sformatf("%s pixel %0d red", test_name, num), c[4:0], red);
    check_channel($sformatf("%s pixel %0d green", test_name, num), c[9:5], green);
    check_channel($sformatf("%s pixel %0d blue", test_name, num), c[14:10], blue);
    if (t) begin
        checked_cnt++;
    end
endtask

task automatic test_reset();
    test_name = "reset";
    @(negedge clk);
    check_flag("reset lhbl_dly", 1'b0, lhbl_dly);
    check_flag("reset lvbl_dly", 1'b0, lvbl_dly);
    check_channel("reset red", '0, red);
    check_channel("reset green", '0, green);
    check_channel("reset blue", '0, blue);
endtask

task automatic test_cpu_rw();
    int i;
    int rnd;
    test_name = "cpu read back";
    for (i = 0; i < colmix_pkg::PAL_DEPTH; i++) begin
        rnd = $random(seed);
        cpu_write(i[7:0], rnd[7:0]);
    end
    for (i = 0; i < colmix_pkg::PAL_DEPTH; i++) begin
        cpu_read_check(i[7:0]);
    end
endtask

// Every index back to back, visible
task automatic test_lookup();
    int i;
    test_name = "lookup";
    for (i = 0; i < 128; i++) begin
        push_pixel(i[6:0], 1'b1, 1'b1);
    end
    wait_stream_done(400);
endtask

task automatic test_blanking();
    int   i;
    int   rnd;
    logic h;
    logic v;
    test_name = "blanking";
    for (i = 0; i < 32; i++) begin
        rnd = $random(seed);
        // Short runs and single pixels, pixel 28 has both low
        h = !((i >= 6 && i < 10) || i == 20 || i == 28);
        v = !((i >= 14 && i < 17) || i == 25 || i == 28);
        push_pixel(rnd[6:0], h, v);
    end
    wait_stream_done(100);
endtask

task automatic test_palette_update();
    int                     i;
    int                     rnd;
    colmix_pkg::col_index_t picks [4];
    test_name = "palette update";
    // Vertical blank around the rewrite
    for (i = 0; i < 8; i++) begin
        push_pixel(7'd0, 1'b1, 1'b0);
    end
    for (i = 0; i < 4; i++) begin
        rnd = $random(seed);
        picks[i] = rnd[6:0];
        // Unused top bit set on every other entry
        cpu_write({picks[i], 1'b0}, {i[0], rnd[14:8]});
        cpu_write({picks[i], 1'b1}, rnd[23:16]);
    end
    // Next frame shows each new colour twice
    for (i = 0; i < 8; i++) begin
        push_pixel(picks[i / 2], 1'b1, 1'b1);
    end
    wait_stream_done(200);
endtask

`endif

//--- tests/tb_colmix.sv
`timescale 1ns/1ps

// Testbench for the palette colour mixer
module tb_colmix;

    logic                   clk;
    logic                   rst;
    logic                   pxl_cen;
    logic                   lhbl;
    logic                   lvbl;
    colmix_pkg::col_index_t gfx_pxl;
    logic                   pal_cs;
    logic                   cpu_rnw;
    logic                   cpu_cen;
    colmix_pkg::pal_addr_t  cpu_addr;
    colmix_pkg::pal_byte_t  cpu_dout;
    colmix_pkg::pal_byte_t  pal_dout;
    logic                   lhbl_dly;
    logic                   lvbl_dly;
    colmix_pkg::channel_t   red;
    colmix_pkg::channel_t   green;
    colmix_pkg::channel_t   blue;

    // Pixels queued by the tests for the video driver
    colmix_pkg::col_index_t stim_idx_q [$];
    logic                   stim_hbl_q [$];
    logic                   stim_vbl_q [$];
    // Strobed pixel came from a test, not idle filler
    logic                   from_test;
    logic                   video_on;

    // Pixels in flight, captured at their own strobe
    logic                   hbl_q [$];
    logic                   vbl_q [$];
    logic                   tag_q [$];
    int                     num_q [$];
    colmix_pkg::colour_t    exp_q [$];

    int    strobe_cnt = 0;
    int    pushed_cnt = 0;
    int    checked_cnt = 0;
    int    seed = 2;
    string test_name;

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    colmix_top UUT (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .gfx_pxl  (gfx_pxl),
        .pal_cs   (pal_cs),
        .cpu_rnw  (cpu_rnw),
        .cpu_cen  (cpu_cen),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .pal_dout (pal_dout),
        .lhbl_dly (lhbl_dly),
        .lvbl_dly (lvbl_dly),
        .red      (red),
        .green    (green),
        .blue     (blue)
    );

    `include "tb_colmix_tasks.svh"

    // Video driver, strobe every second clock once started
    initial begin
        pxl_cen   = 1'b0;
        gfx_pxl   = '0;
        lhbl      = 1'b0;
        lvbl      = 1'b0;
        from_test = 1'b0;
        forever begin
            @(negedge clk);
            if (video_on && !pxl_cen) begin
                pxl_cen = 1'b1;
                if (stim_idx_q.size() > 0) begin
                    gfx_pxl   = stim_idx_q.pop_front();
                    lhbl      = stim_hbl_q.pop_front();
                    lvbl      = stim_vbl_q.pop_front();
                    from_test = 1'b1;
                end else begin
                    // Nothing queued, so send a blanked pixel
                    gfx_pxl   = '0;
                    lhbl      = 1'b0;
                    lvbl      = 1'b0;
                    from_test = 1'b0;
                end
            end else begin
                pxl_cen = 1'b0;
            end
        end
    end

    // Scoreboard, record on strobe edges and check on the edge after
    always @(posedge clk) begin
        if (pxl_cen) begin
            hbl_q.push_back(lhbl);
            vbl_q.push_back(lvbl);
            tag_q.push_back(from_test);
            num_q.push_back(strobe_cnt);
            // Palette as it stands when the fetch starts
            exp_q.push_back(expected_colour(gfx_pxl));
            strobe_cnt++;
        end else if (num_q.size() > 0 &&
                     num_q[0] + colmix_pkg::PIPE_DLY == strobe_cnt - 1) begin
            check_pixel();
        end
    end

    initial begin
        rst      = 1'b1;
        video_on = 1'b0;
        pal_cs   = 1'b0;
        cpu_rnw  = 1'b1;
        cpu_cen  = 1'b0;
        cpu_addr = '0;
        cpu_dout = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_reset();
        // Start the pixel stream
        video_on = 1'b1;
        test_cpu_rw();
        test_lookup();
        test_blanking();
        test_palette_update();
        $display("all tests passed");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+tests
hdl/colmix_pkg.sv
hdl/pal_cpu_if.sv
hdl/video_in_if.sv
hdl/palette_ram.sv
hdl/colour_fetch.sv
hdl/blank_delay.sv
hdl/rgb_mixer.sv
hdl/colmix_top.sv
tests/tb_colmix.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the colour mixer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_colmix \
    -f filelist.f -o sim_colmix && ./obj_dir/sim_colmix > sim.log 2>&1
cat sim.log 2>/dev/null
# No log, or the fail message in it, counts as a failed run
test -s sim.log || exit 1
grep -q "tests failed" sim.log && exit 1 || exit 0
